// File: common/clockPkg.sv
package clockPkg;

   ////////////////////
   // Field limits
   ////////////////////

   localparam int MAX_HOUR        = 23;
   localparam int MAX_MINUTE      = 59;
   localparam int MAX_SECOND      = 59;
   localparam int MAX_CENTISECOND = 99;

   ////////////////////
   // Time types
   ////////////////////

   // Tens digit in [7:4], units digit in [3:0]
   typedef logic [7:0] bcdPair_t;

   typedef struct packed {
      bcdPair_t hours;
      bcdPair_t minutes;
      bcdPair_t seconds;
      bcdPair_t centiseconds;
   } bcdTime_t;

   // Binary value that comes with a set strobe
   typedef logic [7:0] setValue_t;

   typedef enum logic [1:0] {
      setView   = 2'd0,
      clockView = 2'd1,
      timerView = 2'd2
   } viewMode_e;

   typedef enum logic [1:0] {
      loadNone   = 2'd0,
      loadSecond = 2'd1,
      loadMinute = 2'd2,
      loadHour   = 2'd3
   } loadSel_e;

   // Command word from the decode stage to the counters
   typedef struct packed {
      loadSel_e  loadSel;
      bcdPair_t  loadValue;
      logic      clockRun;
      logic      timerRun;
      logic      timerClear;
      viewMode_e view;
   } keeperCmd_t;

   // Binary 0..99 to two BCD digits
   function automatic bcdPair_t binToBcd(input setValue_t value);
      setValue_t tens;
      setValue_t units;
      tens  = value / 8'd10;
      units = value % 8'd10;
      return {tens[3:0], units[3:0]};
   endfunction

endpackage

// File: src/modeController.sv
`timescale 1ns/1ps

module modeController
   import clockPkg::*;
(
   input  logic       CLK100HZ,
   input  logic       RESETa,
   input  logic       setSecond,
   input  logic       setMinute,
   input  logic       setHour,
   input  logic       showTime,
   input  logic       timerStart,
   input  logic       pauseTimer,
   input  logic       continueTimer,
   input  setValue_t  setValue,
   output keeperCmd_t keeperCmd
);

   viewMode_e viewState;
   logic      clockRun;
   logic      timerRun;
   logic      timerClear;
   loadSel_e  loadSel;
   bcdPair_t  loadValue;
   logic      setAllowed;

   // Field sets are locked out while the timer is on screen
   assign setAllowed = (viewState != timerView);

   ////////////////////
   // Command decode
   ////////////////////

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         viewState  <= setView;
         clockRun   <= 1'b0;
         timerRun   <= 1'b0;
         timerClear <= 1'b0;
         loadSel    <= loadNone;
      end else begin
         // One-cycle pulses by default
         timerClear <= 1'b0;
         loadSel    <= loadNone;

         if (setSecond) begin
            if (setAllowed && (setValue <= MAX_SECOND)) begin
               loadSel   <= loadSecond;
               viewState <= setView;
            end
         end else if (setMinute) begin
            if (setAllowed && (setValue <= MAX_MINUTE)) begin
               loadSel   <= loadMinute;
               viewState <= setView;
            end
         end else if (setHour) begin
            if (setAllowed && (setValue <= MAX_HOUR)) begin
               loadSel   <= loadHour;
               viewState <= setView;
            end
         end else if (showTime) begin
            clockRun  <= 1'b1;
            viewState <= clockView;
         end else if (timerStart) begin
            timerClear <= 1'b1;
            timerRun   <= 1'b1;
            viewState  <= timerView;
         end else if (pauseTimer) begin
            timerRun  <= 1'b0;
            viewState <= timerView;
         end else if (continueTimer) begin
            timerRun  <= 1'b1;
            viewState <= timerView;
         end
      end
   end

   // BCD form of the set value, registered alongside loadSel
   always_ff @(posedge CLK100HZ) begin
      loadValue <= binToBcd(setValue);
   end

   assign keeperCmd = '{
      loadSel:    loadSel,
      loadValue:  loadValue,
      clockRun:   clockRun,
      timerRun:   timerRun,
      timerClear: timerClear,
      view:       viewState
   };

endmodule

// File: timekeeping/timeKeeping.sv
`timescale 1ns/1ps

module timeKeeping
   import clockPkg::*;
(
   input  logic       CLK100HZ,
   input  logic       RESETa,
   input  keeperCmd_t keeperCmd,
   output bcdTime_t   clockTime,
   output bcdTime_t   timerTime,
   output viewMode_e  view
);

   ////////////////////
   // Digit cascade
   ////////////////////

   // Adds one centisecond; fields are walked from centiseconds up to hours
   function automatic bcdTime_t advance(input bcdTime_t now);
      bcdPair_t [3:0] field;
      bcdPair_t       last;
      logic           carry;
      field = now;
      carry = 1'b1;
      for (int i = 0; i < 4; i++) begin
         case (i)
            0:       last = binToBcd(setValue_t'(MAX_CENTISECOND));
            1:       last = binToBcd(setValue_t'(MAX_SECOND));
            2:       last = binToBcd(setValue_t'(MAX_MINUTE));
            default: last = binToBcd(setValue_t'(MAX_HOUR));
         endcase
         if (carry) begin
            if (field[i] == last) begin
               // Field rolls over and carries into the next one
               field[i] = '0;
            end else begin
               carry = 1'b0;
               if (field[i][3:0] == 4'd9) begin
                  field[i] = {field[i][7:4] + 4'd1, 4'd0};
               end else begin
                  field[i][3:0] = field[i][3:0] + 4'd1;
               end
            end
         end
      end
      return field;
   endfunction

   ////////////////////
   // Time of day
   ////////////////////

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         clockTime <= '0;
      end else begin
         case (keeperCmd.loadSel)
            loadSecond: clockTime.seconds <= keeperCmd.loadValue;
            loadMinute: clockTime.minutes <= keeperCmd.loadValue;
            loadHour:   clockTime.hours   <= keeperCmd.loadValue;
            default: begin
               if (keeperCmd.clockRun) begin
                  clockTime <= advance(clockTime);
               end
            end
         endcase
      end
   end

   ////////////////////
   // Stopwatch
   ////////////////////

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         timerTime <= '0;
      end else if (keeperCmd.timerClear) begin
         timerTime <= '0;
      end else if (keeperCmd.timerRun) begin
         timerTime <= advance(timerTime);
      end
   end

   // View follows the times by one register
   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         view <= setView;
      end else begin
         view <= keeperCmd.view;
      end
   end

endmodule

// File: src/displaySelect.sv
`timescale 1ns/1ps

module displaySelect
   import clockPkg::*;
(
   input  logic      CLK100HZ,
   input  logic      RESETa,
   input  bcdTime_t  clockTime,
   input  bcdTime_t  timerTime,
   input  viewMode_e view,
   output bcdTime_t  dispTime,
   output logic      modeClock,
   output logic      modeTimer
);

   ////////////////////
   // Output register
   ////////////////////

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         dispTime  <= '0;
         modeClock <= 1'b0;
         modeTimer <= 1'b0;
      end else begin
         // Set view shows the clock fields being edited
         if (view == timerView) begin
            dispTime <= timerTime;
         end else begin
            dispTime <= clockTime;
         end
         modeClock <= (view == clockView);
         modeTimer <= (view == timerView);
      end
   end

endmodule

// File: src/stopwatchClock.sv
`timescale 1ns/1ps

module stopwatchClock
   import clockPkg::*;
(
   input  logic      CLK100HZ,
   input  logic      RESETa,
   input  logic      setSecond,
   input  logic      setMinute,
   input  logic      setHour,
   input  logic      showTime,
   input  logic      timerStart,
   input  logic      pauseTimer,
   input  logic      continueTimer,
   input  setValue_t setValue,
   output bcdTime_t  dispTime,
   output logic      modeClock,
   output logic      modeTimer
);

   keeperCmd_t keeperCmd;
   bcdTime_t   clockTime;
   bcdTime_t   timerTime;
   viewMode_e  view;

   ////////////////////
   // Command stage
   ////////////////////

   modeController modeController_inst (
      .CLK100HZ      (CLK100HZ),
      .RESETa        (RESETa),
      .setSecond     (setSecond),
      .setMinute     (setMinute),
      .setHour       (setHour),
      .showTime      (showTime),
      .timerStart    (timerStart),
      .pauseTimer    (pauseTimer),
      .continueTimer (continueTimer),
      .setValue      (setValue),
      .keeperCmd     (keeperCmd)
   );

   // Counting stage
   timeKeeping timeKeeping_inst (
      .CLK100HZ  (CLK100HZ),
      .RESETa    (RESETa),
      .keeperCmd (keeperCmd),
      .clockTime (clockTime),
      .timerTime (timerTime),
      .view      (view)
   );

   // Display stage
   displaySelect displaySelect_inst (
      .CLK100HZ  (CLK100HZ),
      .RESETa    (RESETa),
      .clockTime (clockTime),
      .timerTime (timerTime),
      .view      (view),
      .dispTime  (dispTime),
      .modeClock (modeClock),
      .modeTimer (modeTimer)
   );

endmodule

// File: dv/stopwatchClock_props.sv
`timescale 1ns/1ps

module stopwatchClock_props
   import clockPkg::*;
(
   input logic     CLK100HZ,
   input logic     RESETa,
   input bcdTime_t dispTime,
   input logic     modeClock,
   input logic     modeTimer
);

   // Units digit is BCD and the pair stays within its BCD limit
   function automatic logic fieldValid(input bcdPair_t pair, input bcdPair_t limit);
      return (pair[3:0] <= 4'd9) && (pair <= limit);
   endfunction

   modeExclusive: assert property (@(posedge CLK100HZ) disable iff (RESETa)
      !(modeClock && modeTimer))
      else $error("modeClock and modeTimer are high together");

   digitsValid: assert property (@(posedge CLK100HZ) disable iff (RESETa)
      fieldValid(dispTime.hours, 8'h23) && fieldValid(dispTime.minutes, 8'h59) &&
      fieldValid(dispTime.seconds, 8'h59) && fieldValid(dispTime.centiseconds, 8'h99))
      else $error("dispTime holds an invalid digit %h", dispTime);

   modesAfterReset: assert property (@(posedge CLK100HZ)
      $fell(RESETa) |=> (!modeClock && !modeTimer))
      else $error("A mode output is high right after reset");

endmodule

bind stopwatchClock stopwatchClock_props propsInst (
   .CLK100HZ  (CLK100HZ),
   .RESETa    (RESETa),
   .dispTime  (dispTime),
   .modeClock (modeClock),
   .modeTimer (modeTimer)
);

// File: dv/stopwatchClockTb.sv
`timescale 1ns/1ps

module stopwatchClockTb
   import clockPkg::*;
();

   localparam string dataFile   = "dv/stopwatchClock_testdata.txt";
   localparam int    resetCycles = 16;

   logic      CLK100HZ;
   logic      RESETa;
   logic      setSecond;
   logic      setMinute;
   logic      setHour;
   logic      showTime;
   logic      timerStart;
   logic      pauseTimer;
   logic      continueTimer;
   setValue_t setValue;
   bcdTime_t  dispTime;
   logic      modeClock;
   logic      modeTimer;

   // Records from the data file
   string      recCmd[$];
   int         recValue[$];
   int         recWait[$];
   bcdTime_t   recTime[$];
   logic [1:0] recMode[$];

   int waitSum    = 0;
   int cycleCount = 0;
   int cycleLimit = 0;

   stopwatchClock stopwatchClock_inst (
      .CLK100HZ      (CLK100HZ),
      .RESETa        (RESETa),
      .setSecond     (setSecond),
      .setMinute     (setMinute),
      .setHour       (setHour),
      .showTime      (showTime),
      .timerStart    (timerStart),
      .pauseTimer    (pauseTimer),
      .continueTimer (continueTimer),
      .setValue      (setValue),
      .dispTime      (dispTime),
      .modeClock     (modeClock),
      .modeTimer     (modeTimer)
   );

   initial CLK100HZ = 1'b0;
   always #4 CLK100HZ = ~CLK100HZ;

   // Watchdog
   always @(posedge CLK100HZ) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("Run timed out after %0d clock cycles", cycleLimit);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic stopWithError(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "testbench stopped");
   endtask

   task automatic loadRecords();
      int          fd;
      int          nItems;
      int          lineNo;
      string       lineText;
      string       cmdText;
      int          value;
      int          waitCycles;
      logic [31:0] timeBits;
      int          clockBit;
      int          timerBit;
      fd = $fopen(dataFile, "r");
      if (fd == 0) begin
         stopWithError($sformatf("Could not open the data file %s", dataFile));
      end
      lineNo = 0;
      while (!$feof(fd)) begin
         lineText = "";
         void'($fgets(lineText, fd));
         lineNo++;
         if (lineText.len() > 0 && lineText[0] != "#") begin
            nItems = $sscanf(lineText, "%s %d %d %h %d %d", cmdText, value, waitCycles,
                             timeBits, clockBit, timerBit);
            if (nItems == 6) begin
               recCmd.push_back(cmdText);
               recValue.push_back(value);
               recWait.push_back(waitCycles);
               recTime.push_back(bcdTime_t'(timeBits));
               recMode.push_back({clockBit[0], timerBit[0]});
               waitSum += waitCycles;
            end else if (nItems > 0) begin
               stopWithError($sformatf("Line %0d of the data file is malformed", lineNo));
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic clearCommands();
      setSecond     = 1'b0;
      setMinute     = 1'b0;
      setHour       = 1'b0;
      showTime      = 1'b0;
      timerStart    = 1'b0;
      pauseTimer    = 1'b0;
      continueTimer = 1'b0;
      setValue      = '0;
   endtask

   // "none" leaves every strobe low
   task automatic driveCommand(input string cmdText, input int value);
      setValue = setValue_t'(value);
      if (cmdText == "none") begin
         setValue = '0;
      end else if (cmdText == "setSecond") begin
         setSecond = 1'b1;
      end else if (cmdText == "setMinute") begin
         setMinute = 1'b1;
      end else if (cmdText == "setHour") begin
         setHour = 1'b1;
      end else if (cmdText == "showTime") begin
         showTime = 1'b1;
      end else if (cmdText == "timerStart") begin
         timerStart = 1'b1;
      end else if (cmdText == "pauseTimer") begin
         pauseTimer = 1'b1;
      end else if (cmdText == "continueTimer") begin
         continueTimer = 1'b1;
      end else if (cmdText == "setSecond+showTime") begin
         setSecond = 1'b1;
         showTime  = 1'b1;
      end else begin
         stopWithError($sformatf("Unknown command %s in the data file", cmdText));
      end
   endtask

   ////////////////////
   // Checks
   ////////////////////

   task automatic checkTime(input bcdTime_t expected, input string what);
      if (dispTime !== expected) begin
         $display("CHECK FAILED at %0t: %s dispTime %h, expected %h",
                  $time, what, dispTime, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "dispTime mismatch");
      end
   endtask

   // Pair is {modeClock, modeTimer}
   task automatic checkMode(input logic [1:0] expected, input string what);
      if ({modeClock, modeTimer} !== expected) begin
         $display("CHECK FAILED at %0t: %s modes %b%b, expected %b",
                  $time, what, modeClock, modeTimer, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "mode mismatch");
      end
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      string what;
      RESETa = 1'b1;
      clearCommands();
      loadRecords();
      cycleLimit = waitSum + resetCycles + 3 * recCmd.size() + 100;

      repeat (resetCycles) @(posedge CLK100HZ);
      #1;
      RESETa = 1'b0;

      for (int idx = 0; idx < recCmd.size(); idx++) begin
         what = $sformatf("record %0d (%s)", idx + 1, recCmd[idx]);
         driveCommand(recCmd[idx], recValue[idx]);
         // Strobe is high for the first cycle only
         repeat (recWait[idx]) begin
            @(posedge CLK100HZ);
            #1;
            clearCommands();
         end
         checkTime(recTime[idx], what);
         checkMode(recMode[idx], what);
      end

      if (recCmd.size() > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("The data file holds no records");
         $display("SOME TESTS FAILED");
         $fatal(1, "empty data file");
      end
   end

endmodule

// File: dv/stopwatchClock_testdata.txt
# command setValue(decimal) wait(cycles from pulse to compare) dispTime(hhmmsscc) modeClock modeTimer
# Command none drives no strobe
# After reset with the clock stopped
none 0 5 00000000 0 0
# Setting in setView
setHour 23 3 23000000 0 0
setMinute 59 3 23590000 0 0
setSecond 58 3 23595800 0 0
setMinute 75 4 23595800 0 0
setHour 24 4 23595800 0 0
none 0 20 23595800 0 0
# Clock runs and wraps through midnight
showTime 0 10 23595808 1 0
none 0 200 00000008 1 0
# Timer start, pause, continue
timerStart 0 10 00000007 0 1
none 0 93 00000100 0 1
pauseTimer 0 10 00000102 0 1
none 0 30 00000102 0 1
pauseTimer 0 5 00000102 0 1
continueTimer 0 10 00000110 0 1
# Set in timerView is ignored
setHour 5 6 00000116 0 1
# Clock kept counting in the background
showTime 0 10 00000182 1 0
# Same-cycle strobes, setSecond wins
setSecond+showTime 30 5 00003086 0 0
showTime 0 4 00003090 1 0
# Restart clears the timer
timerStart 0 10 00000007 0 1

// File: compile.f
common/clockPkg.sv
src/modeController.sv
timekeeping/timeKeeping.sv
src/displaySelect.sv
src/stopwatchClock.sv
dv/stopwatchClock_props.sv
dv/stopwatchClockTb.sv

// File: Makefile
# Verilator build and run for the stopwatch clock testbench

VERILATOR ?= verilator
TOP       ?= stopwatchClockTb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

FAIL_MSG  := SOME TESTS FAILED
SIM_BIN    = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
